//--- src/mem_pkg.sv
package mem_pkg;

    // word address width and depth of the data RAM
    localparam int RAM_ADDR_BITS = 8;
    localparam int DATA_RAM_WORDS = 256;

    // access width of a load or store
    typedef enum logic [1:0] {
        MEM_WORD = 2'd0,
        MEM_HALF = 2'd1,
        MEM_BYTE = 2'd2
    } mem_size_t;

    typedef struct packed {
        logic is_mem;
        // zero-extend on load
        logic is_unsigned;
        logic is_store;
        mem_size_t size;
    } mem_op_t;

    // bundle from execute
    typedef struct packed {
        logic is_break;
        mem_op_t op;
        logic inst_valid;
        logic [31:0] pc;
        logic [31:0] inst;
        logic [4:0] wreg_index;
        logic wreg_en;
        logic [31:0] store_data;
        // also the byte address for loads and stores
        logic [31:0] alu_result;
    } ex_to_mem_t;

    // bundle towards write-back
    typedef struct packed {
        logic is_break;
        logic inst_valid;
        logic [4:0] wreg_index;
        logic wreg_en;
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] result;
    } mem_to_wb_t;

    // forwarded to decode
    typedef struct packed {
        logic [31:0] result;
        logic [4:0] wreg_index;
        logic wreg_en;
    } bypass_t;

endpackage

//--- src/store_align.sv
`timescale 1ns/1ps

module store_align (
    input  mem_pkg::mem_size_t size,
    input  logic [1:0]         offset,
    input  logic [31:0]        store_data,
    output logic [31:0]        wdata,
    output logic [3:0]         wmask
);
    import mem_pkg::*;

    always_comb begin
        case (size)
            MEM_BYTE: begin
                // byte copied to every lane, mask picks the one written
                wdata = {4{store_data[7:0]}};
                wmask = 4'b0001 << offset;
            end
            MEM_HALF: begin
                // only offset[1] matters for halfwords
                wdata = {2{store_data[15:0]}};
                if (offset[1]) begin
                    wmask = 4'b1100;
                end else begin
                    wmask = 4'b0011;
                end
            end
            MEM_WORD: begin
                wdata = store_data;
                wmask = 4'b1111;
            end
            default: begin
                // unused size code, nothing gets written
                wdata = store_data;
                wmask = 4'b0000;
            end
        endcase
    end

endmodule

//--- src/load_extract.sv
`timescale 1ns/1ps

module load_extract (
    input  mem_pkg::mem_size_t size,
    input  logic               is_unsigned,
    input  logic [1:0]         offset,
    input  logic [31:0]        rdata,
    output logic [31:0]        value
);
    import mem_pkg::*;

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // lane select, same offset rules as the store side
    assign byte_lane = rdata[offset*8 +: 8];
    assign half_lane = offset[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (size)
            MEM_BYTE: begin
                if (is_unsigned) begin
                    value = {24'h0, byte_lane};
                end else begin
                    value = {{24{byte_lane[7]}}, byte_lane};
                end
            end
            MEM_HALF: begin
                if (is_unsigned) begin
                    value = {16'h0, half_lane};
                end else begin
                    value = {{16{half_lane[15]}}, half_lane};
                end
            end
            // words and the unused code pass straight through
            default: begin
                value = rdata;
            end
        endcase
    end

endmodule

//--- src/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                              clk,
    input  logic                              reset,
    input  mem_pkg::ex_to_mem_t               in_bundle,
    input  logic                              in_valid,
    output logic                              in_ready,
    output mem_pkg::mem_to_wb_t               out_bundle,
    output logic                              out_valid,
    input  logic                              out_ready,
    output mem_pkg::bypass_t                  bypass,
    output logic                              ram_en,
    output logic                              ram_we,
    output logic [mem_pkg::RAM_ADDR_BITS-1:0] ram_addr,
    output logic [3:0]                        ram_wmask,
    output logic [31:0]                       ram_wdata,
    input  logic [31:0]                       ram_rdata
);
    import mem_pkg::*;

    logic       accept;
    logic       is_load;
    logic [31:0] load_value;
    logic [31:0] mem_result;

    // the stage never stalls on its own
    assign in_ready = out_ready;
    assign accept = in_valid && out_ready;

    store_align u_store_align (
        .size       (in_bundle.op.size),
        .offset     (in_bundle.alu_result[1:0]),
        .store_data (in_bundle.store_data),
        .wdata      (ram_wdata),
        .wmask      (ram_wmask)
    );

    load_extract u_load_extract (
        .size        (in_bundle.op.size),
        .is_unsigned (in_bundle.op.is_unsigned),
        .offset      (in_bundle.alu_result[1:0]),
        .rdata       (ram_rdata),
        .value       (load_value)
    );

    // only enabled on the accepting edge so a stalled store writes once
    assign ram_en = in_bundle.op.is_mem && in_bundle.inst_valid && accept;
    assign ram_we = in_bundle.op.is_store;
    assign ram_addr = in_bundle.alu_result[RAM_ADDR_BITS+1:2];

    assign is_load = in_bundle.op.is_mem && !in_bundle.op.is_store;
    assign mem_result = is_load ? load_value : in_bundle.alu_result;

    // forwarding path, combinational from the incoming bundle
    assign bypass.result = mem_result;
    assign bypass.wreg_index = in_bundle.wreg_index;
    assign bypass.wreg_en = in_bundle.wreg_en && in_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (out_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_bundle <= '0;
        end else if (accept) begin
            out_bundle.is_break   <= in_bundle.is_break;
            out_bundle.inst_valid <= in_bundle.inst_valid;
            out_bundle.wreg_index <= in_bundle.wreg_index;
            out_bundle.wreg_en    <= in_bundle.wreg_en;
            out_bundle.inst       <= in_bundle.inst;
            out_bundle.pc         <= in_bundle.pc;
            out_bundle.result     <= mem_result;
        end
    end

    // write-back must see the same item until it takes it
    a_hold_while_stalled: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_bundle)
    ) else $error("out_bundle changed while stalled");

    // a write must touch at least one byte of the RAM
    a_write_has_mask: assert property (
        @(posedge clk) disable iff (reset)
        ram_en && ram_we |-> ram_wmask != 4'b0000
    ) else $error("RAM write with empty byte mask");

endmodule

//--- src/data_ram.sv
`timescale 1ns/1ps

module data_ram (
    input  logic                              clk,
    input  logic                              en,
    input  logic                              we,
    input  logic [mem_pkg::RAM_ADDR_BITS-1:0] addr,
    input  logic [3:0]                        wmask,
    input  logic [31:0]                       wdata,
    output logic [31:0]                       rdata
);
    import mem_pkg::*;

    logic [31:0] mem [0:DATA_RAM_WORDS-1];

    // byte-masked write on the clock edge
    always_ff @(posedge clk) begin
        if (en && we) begin
            for (int i = 0; i < 4; i++) begin
                if (wmask[i]) begin
                    mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    // asynchronous read, used by the stage in the same cycle
    assign rdata = mem[addr];

    // the stage must present a clean word index whenever it enables the RAM
    a_addr_known: assert property (
        @(posedge clk) en |-> !$isunknown(addr)
    ) else $error("data RAM enabled with unknown address");

endmodule

//--- src/mem_top.sv
`timescale 1ns/1ps

module mem_top (
    input  logic                clk,
    input  logic                reset,
    input  mem_pkg::ex_to_mem_t in_bundle,
    input  logic                in_valid,
    output logic                in_ready,
    output mem_pkg::mem_to_wb_t out_bundle,
    output logic                out_valid,
    input  logic                out_ready,
    output mem_pkg::bypass_t    bypass
);
    import mem_pkg::*;

    // stage to RAM request
    logic                     ram_en;
    logic                     ram_we;
    logic [RAM_ADDR_BITS-1:0] ram_addr;
    logic [3:0]               ram_wmask;
    logic [31:0]              ram_wdata;
    logic [31:0]              ram_rdata;

    mem_stage u_mem_stage (
        .clk        (clk),
        .reset      (reset),
        .in_bundle  (in_bundle),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_bundle (out_bundle),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .bypass     (bypass),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_wmask  (ram_wmask),
        .ram_wdata  (ram_wdata),
        .ram_rdata  (ram_rdata)
    );

    data_ram u_data_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wmask (ram_wmask),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

endmodule

//--- testbench/tb_mem_top.sv
`timescale 1ns/1ps

module tb_mem_top;
    import mem_pkg::*;

    localparam int MAX_VECS = 64;
    localparam int TIMEOUT = 200;

    logic       clk;
    logic       reset;
    ex_to_mem_t in_bundle;
    logic       in_valid;
    logic       in_ready;
    mem_to_wb_t out_bundle;
    logic       out_valid;
    logic       out_ready;
    bypass_t    bypass;

    // four words per vector: op, address, store data, expected result
    logic [31:0] vec_mem [0:MAX_VECS*4-1];
    int          num_vecs;
    int          cur_idx;
    int          outputs_seen;
    int          pending_q[$];
    int          mismatch_count;
    int          failure_count;
    integer      seed;
    bit          checks_on;
    logic        stalled_prev;
    mem_to_wb_t  held_bundle;

    tb_clock u_clock (.clk(clk));

    mem_top uut (.*);

    task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s, got %0h expected %0h",
                     $time, msg, actual, expected);
            mismatch_count++;
        end
    endtask

    // pc, inst, break flag and destination register come from the vector number
    function automatic ex_to_mem_t make_bundle(input int idx);
        ex_to_mem_t b;
        b = '0;
        b.is_break = (idx % 4) == 3;
        b.op = mem_op_t'(vec_mem[idx*4][4:0]);
        b.inst_valid = 1'b1;
        b.pc = 32'h0000_1000 + 32'(idx) * 32'd4;
        b.inst = 32'h00c0_0000 + 32'(idx);
        b.wreg_index = 5'((idx % 31) + 1);
        b.wreg_en = !b.op.is_store;
        b.store_data = vec_mem[idx*4+2];
        b.alu_result = vec_mem[idx*4+1];
        return b;
    endfunction

    function automatic mem_to_wb_t expected_wb(input int idx);
        ex_to_mem_t b;
        mem_to_wb_t w;
        b = make_bundle(idx);
        w.is_break = b.is_break;
        w.inst_valid = 1'b1;
        w.wreg_index = b.wreg_index;
        w.wreg_en = b.wreg_en;
        w.inst = b.inst;
        w.pc = b.pc;
        w.result = vec_mem[idx*4+3];
        return w;
    endfunction

    // write-back ready about three cycles in four
    function automatic logic random_ready();
        int r;
        r = $random(seed);
        return (r & 3) != 0;
    endfunction

    // mid-cycle sampling, inputs were driven 1 ns after the rising edge
    always @(negedge clk) begin
        ex_to_mem_t b;
        bypass_t    exp_bypass;
        int         idx;
        if (checks_on) begin
            check_value(in_ready, out_ready, "in_ready does not follow out_ready");
            if (in_valid) begin
                b = make_bundle(cur_idx);
                exp_bypass.result = vec_mem[cur_idx*4+3];
                exp_bypass.wreg_index = b.wreg_index;
                exp_bypass.wreg_en = b.wreg_en;
                check_value(bypass, exp_bypass, $sformatf("bypass for vector %0d", cur_idx));
            end else begin
                check_value(bypass.wreg_en, 1'b0, "bypass wreg_en without valid input");
            end
            if (!reset) begin
                if (stalled_prev) begin
                    check_value({out_valid, out_bundle}, {1'b1, held_bundle},
                                "output changed while stalled");
                end
                if (out_valid && out_ready) begin
                    if (pending_q.size() == 0) begin
                        $display("output taken at %0t with no transaction pending", $time);
                        failure_count++;
                    end else begin
                        idx = pending_q.pop_front();
                        check_value(out_bundle, expected_wb(idx),
                                    $sformatf("write-back for vector %0d", idx));
                        outputs_seen++;
                    end
                end
                stalled_prev = out_valid && !out_ready;
                held_bundle = out_bundle;
                if (in_valid && out_ready) begin
                    pending_q.push_back(cur_idx);
                end
            end
        end
    end

    initial begin
        int   waited;
        logic taken;
        seed = 32'hc1b16138;
        mismatch_count = 0;
        failure_count = 0;
        outputs_seen = 0;
        cur_idx = 0;
        stalled_prev = 1'b0;
        held_bundle = '0;
        reset = 1'b1;
        in_valid = 1'b0;
        in_bundle = '0;
        out_ready = 1'b0;
        checks_on = 1'b0;
        $readmemh("testbench/mem_testdata.hex", vec_mem);
        num_vecs = 0;
        while (num_vecs < MAX_VECS && vec_mem[num_vecs*4] !== 32'hffff_ffff) begin
            num_vecs++;
        end
        if (num_vecs == 0 || num_vecs == MAX_VECS) begin
            $display("vector file is empty or has no end marker");
            failure_count++;
            num_vecs = 0;
        end

        // reset for 4 cycles, out_ready moving so in_ready is exercised
        for (int c = 0; c < 4; c++) begin
            @(posedge clk);
            #1;
            checks_on = 1'b1;
            out_ready = random_ready();
        end
        check_value(out_valid, 1'b0, "out_valid after reset");
        check_value(out_bundle, '0, "out_bundle after reset");
        reset = 1'b0;

        for (int i = 0; i < num_vecs; i++) begin
            if (($random(seed) & 3) == 0) begin
                in_valid = 1'b0;
                out_ready = random_ready();
                @(posedge clk);
                #1;
            end
            cur_idx = i;
            in_bundle = make_bundle(i);
            in_valid = 1'b1;
            // stores always sit through one stalled cycle first
            out_ready = in_bundle.op.is_store ? 1'b0 : random_ready();
            taken = 1'b0;
            waited = 0;
            while (!taken && waited < TIMEOUT) begin
                @(posedge clk);
                taken = out_ready;
                #1;
                waited++;
                if (!taken) begin
                    out_ready = random_ready();
                end
            end
            if (!taken) begin
                $display("timeout: vector %0d was never accepted", i);
                failure_count++;
            end
        end

        in_valid = 1'b0;
        waited = 0;
        while ((outputs_seen < num_vecs || out_valid) && waited < TIMEOUT) begin
            out_ready = random_ready();
            @(posedge clk);
            #1;
            waited++;
        end
        if (outputs_seen < num_vecs || out_valid) begin
            $display("timeout: write-back outputs did not drain");
            failure_count++;
        end
        check_value(pending_q.size(), 0, "transactions still pending at the end");

        $display("mismatches: %0d, other failures: %0d", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verilog.f
src/mem_pkg.sv
src/store_align.sv
src/load_extract.sv
src/mem_stage.sv
src/data_ram.sv
src/mem_top.sv
testbench/tb_clock.sv
testbench/tb_mem_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_mem_top -f verilog.f -o tb_mem_top_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_mem_top_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$log"; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0

//--- testbench/mem_testdata.hex
// columns: op {is_mem,is_unsigned,is_store,size}, address, store data, expected result
// op 14 sw, 15 sh, 16 sb, 10 lw, 11 lh, 19 lhu, 12 lb, 1a lbu, 00 alu; ffffffff ends the list
14 00000000 11223344 00000000
10 00000000 00000000 11223344
15 00000002 0000aabb 00000002
10 00000000 00000000 aabb3344
16 00000001 000000cc 00000001
16 00000003 000000ee 00000003
10 00000000 00000000 eebbcc44
16 00000010 00000080 00000010
16 00000011 0000007f 00000011
16 00000012 123456f0 00000012
16 00000013 00000001 00000013
10 00000010 00000000 01f07f80
15 00000014 dead8001 00000014
15 00000016 00007ffe 00000016
10 00000014 00000000 7ffe8001
12 00000010 00000000 ffffff80
1a 00000010 00000000 00000080
12 00000011 00000000 0000007f
12 00000012 00000000 fffffff0
1a 00000012 00000000 000000f0
1a 00000013 00000000 00000001
11 00000014 00000000 ffff8001
19 00000014 00000000 00008001
11 00000016 00000000 00007ffe
19 00000017 00000000 00007ffe
00 00000010 ffffffff 00000010
10 00000010 00000000 01f07f80
00 cafef00d 00000000 cafef00d
14 00000020 5a5aa5a5 00000020
16 00000021 0000003c 00000021
10 00000020 00000000 5a5a3ca5
ffffffff ffffffff ffffffff ffffffff
